// File: tb/hm_tb.sv
`timescale 1ns/10ps
`default_nettype none

module hm_tb import hm_trn_pkg::*, hm_sys_pkg::*; ();

localparam int settle_cycles = 8;
localparam int watchdog_cycles = 4000; // Several times the stimulus length.

logic sys_clk;
logic trn_clk;
logic reset;
logic rx_start;
logic rx_done;
logic tx_start;
logic tx_done;
logic bar_wr;
logic bar_rd;
logic [hm_bar_num_width-1:0] bar_num;
logic lnk_up_n;
logic bitmap_wr;
logic [hm_bar_count-1:0] bitmap_data;
logic flag_clear;
hm_sys_flags_t flags;
logic [hm_event_count_width-1:0] rx_timeout_count;
logic [hm_event_count_width-1:0] tx_timeout_count;
logic [hm_bar_num_width-1:0] last_bar_number;
logic [hm_bar_count-1:0] bar_bitmap;
hm_trn_counts_t sys_counts;
hm_xfer_state_t sys_state_rx;
hm_xfer_state_t sys_state_tx;
hm_xfer_state_t sys_state;
logic sys_lnk_up_n;

// Reference model.
hm_trn_counts_t exp_counts;
hm_sys_flags_t exp_flags;
int exp_rx_to;
int exp_tx_to;
logic [hm_bar_num_width-1:0] exp_last_bar;
logic [hm_bar_count-1:0] exp_bitmap;
integer seed;
int cycles;

hm_top hm_top_i (
	.sys_clk(sys_clk),
	.trn_clk(trn_clk),
	.reset(reset),
	.rx_start(rx_start),
	.rx_done(rx_done),
	.tx_start(tx_start),
	.tx_done(tx_done),
	.bar_wr(bar_wr),
	.bar_rd(bar_rd),
	.bar_num(bar_num),
	.lnk_up_n(lnk_up_n),
	.bitmap_wr(bitmap_wr),
	.bitmap_data(bitmap_data),
	.flag_clear(flag_clear),
	.flags(flags),
	.rx_timeout_count(rx_timeout_count),
	.tx_timeout_count(tx_timeout_count),
	.last_bar_number(last_bar_number),
	.bar_bitmap(bar_bitmap),
	.sys_counts(sys_counts),
	.sys_state_rx(sys_state_rx),
	.sys_state_tx(sys_state_tx),
	.sys_state(sys_state),
	.sys_lnk_up_n(sys_lnk_up_n)
);

initial begin
	sys_clk = 1'b0;
	forever #5 sys_clk = ~sys_clk;
end

initial begin
	trn_clk = 1'b0;
	forever #4 trn_clk = ~trn_clk;
end

task automatic report_failure(input string what);
	$display("%s", what);
	$display("Test failures found");
	$fatal(1);
endtask

task automatic check_value(input string test, input string what,
	input logic [31:0] expected, input logic [31:0] actual);
	assert (actual === expected)
		else report_failure($sformatf("FAILED %s %s: expected %0h, actual %0h",
			test, what, expected, actual));
endtask

task automatic check_all(input string test);
	check_value(test, "cpt_rx", exp_counts.cpt_rx, sys_counts.cpt_rx);
	check_value(test, "cpt_tx", exp_counts.cpt_tx, sys_counts.cpt_tx);
	check_value(test, "cpt_drop", exp_counts.cpt_drop, sys_counts.cpt_drop);
	check_value(test, "flags", 32'(exp_flags), 32'(flags));
	check_value(test, "rx_timeout_count", exp_rx_to, 32'(rx_timeout_count));
	check_value(test, "tx_timeout_count", exp_tx_to, 32'(tx_timeout_count));
	check_value(test, "last_bar_number", 32'(exp_last_bar), 32'(last_bar_number));
	check_value(test, "bar_bitmap", exp_bitmap, bar_bitmap);
	check_value(test, "state_rx", 32'(xfer_idle), 32'(sys_state_rx));
	check_value(test, "state_tx", 32'(xfer_idle), 32'(sys_state_tx));
	check_value(test, "state", 32'(xfer_idle), 32'(sys_state));
	check_value(test, "lnk_up_n", 32'(lnk_up_n), 32'(sys_lnk_up_n));
endtask

function automatic int random_between(input int lo, input int hi);
	return lo + int'({$random(seed)} % (hi - lo + 1));
endfunction

task automatic settle();
	repeat (settle_cycles) @(negedge sys_clk);
endtask

// Delay counts trn cycles from the start strobe to the done strobe.
task automatic run_xfer(input bit tx, input int delay);
	int limit;
	limit = tx ? hm_tx_timeout_cycles : hm_rx_timeout_cycles;
	@(negedge trn_clk);
	if (tx) begin
		tx_start = 1'b1;
	end else begin
		rx_start = 1'b1;
	end
	@(negedge trn_clk);
	rx_start = 1'b0;
	tx_start = 1'b0;
	repeat (delay - 1) @(negedge trn_clk);
	if (tx) begin
		tx_done = 1'b1;
	end else begin
		rx_done = 1'b1;
	end
	if (!lnk_up_n) begin
		if (delay <= limit && tx) begin
			exp_counts.cpt_tx = exp_counts.cpt_tx + 1;
			exp_flags.hm_end = 1'b1;
		end else if (delay <= limit) begin
			exp_counts.cpt_rx = exp_counts.cpt_rx + 1;
		end else if (tx) begin
			exp_tx_to++; // Late done lands after the timeout.
			exp_flags.tx_timeout = 1'b1;
		end else begin
			exp_rx_to++;
			exp_flags.rx_timeout = 1'b1;
		end
	end
	@(negedge trn_clk);
	rx_done = 1'b0;
	tx_done = 1'b0;
	settle();
endtask

task automatic bar_access(input bit write, input logic [hm_bar_num_width-1:0] bar);
	logic hit;
	hit = exp_bitmap[bar];
	@(negedge trn_clk);
	bar_num = bar;
	if (write) begin
		bar_wr = 1'b1;
	end else begin
		bar_rd = 1'b1;
	end
	if (!lnk_up_n) begin
		if (write && hit) begin
			exp_flags.write_bar = 1'b1;
			exp_last_bar = bar;
		end else if (write) begin
			exp_counts.cpt_drop = exp_counts.cpt_drop + 1;
		end else if (!hit) begin
			exp_flags.read_exp = 1'b1;
		end
	end
	@(negedge trn_clk);
	bar_wr = 1'b0;
	bar_rd = 1'b0;
	settle();
endtask

task automatic write_bitmap(input logic [hm_bar_count-1:0] value);
	@(negedge sys_clk);
	bitmap_wr = 1'b1;
	bitmap_data = value;
	exp_bitmap = value;
	@(negedge sys_clk);
	bitmap_wr = 1'b0;
	settle();
endtask

task automatic clear_flags();
	@(negedge sys_clk);
	flag_clear = 1'b1;
	exp_flags = '0;
	@(negedge sys_clk);
	flag_clear = 1'b0;
	settle();
endtask

task automatic set_link(input logic value);
	@(negedge trn_clk);
	lnk_up_n = value;
	settle();
endtask

a_cpt_rx_bounded: assert property (@(posedge sys_clk) disable iff (reset)
	sys_counts.cpt_rx >= $past(sys_counts.cpt_rx) && sys_counts.cpt_rx <= exp_counts.cpt_rx)
	else report_failure("Counter cpt_rx went backwards or ran ahead of the model");

a_cpt_tx_bounded: assert property (@(posedge sys_clk) disable iff (reset)
	sys_counts.cpt_tx >= $past(sys_counts.cpt_tx) && sys_counts.cpt_tx <= exp_counts.cpt_tx)
	else report_failure("Counter cpt_tx went backwards or ran ahead of the model");

a_cpt_drop_bounded: assert property (@(posedge sys_clk) disable iff (reset)
	sys_counts.cpt_drop >= $past(sys_counts.cpt_drop) &&
	sys_counts.cpt_drop <= exp_counts.cpt_drop)
	else report_failure("Counter cpt_drop went backwards or ran ahead of the model");

initial begin
	cycles = 0;
	while (cycles < watchdog_cycles) begin
		@(posedge sys_clk);
		cycles++;
	end
	report_failure($sformatf("Simulation timed out after %0d sys cycles", watchdog_cycles));
end

initial begin
	int en_bar;
	int dis_bar;
	logic [hm_bar_count-1:0] pattern;
	seed = 32'heac5;
	reset = 1'b1;
	rx_start = 1'b0;
	rx_done = 1'b0;
	tx_start = 1'b0;
	tx_done = 1'b0;
	bar_wr = 1'b0;
	bar_rd = 1'b0;
	bar_num = '0;
	lnk_up_n = 1'b1; // Link starts down.
	bitmap_wr = 1'b0;
	bitmap_data = '0;
	flag_clear = 1'b0;
	exp_counts = '0;
	exp_flags = '0;
	exp_rx_to = 0;
	exp_tx_to = 0;
	exp_last_bar = '0;
	exp_bitmap = '0;
	repeat (4) @(negedge sys_clk);
	reset = 1'b0;
	settle();
	check_all("reset");
	set_link(1'b0);
	check_all("link_up");

	for (int n = 0; n < 10; n++) begin
		run_xfer(1'b0, random_between(1, hm_rx_timeout_cycles));
		check_all("rx_xfer");
	end
	for (int n = 0; n < 10; n++) begin
		run_xfer(1'b1, random_between(1, hm_tx_timeout_cycles));
		check_all("tx_xfer");
	end

	for (int n = 0; n < 2; n++) begin
		run_xfer(1'b0, random_between(hm_rx_timeout_cycles + 1, hm_rx_timeout_cycles + 8));
		check_all("rx_timeout");
		run_xfer(1'b1, random_between(hm_tx_timeout_cycles + 1, hm_tx_timeout_cycles + 8));
		check_all("tx_timeout");
	end

	en_bar = random_between(0, hm_bar_count - 1);
	dis_bar = (en_bar + random_between(1, hm_bar_count - 1)) % hm_bar_count;
	pattern = $random(seed);
	pattern[en_bar] = 1'b1;
	pattern[dis_bar] = 1'b0;
	write_bitmap(pattern);
	check_all("bitmap_write");
	bar_access(1'b1, hm_bar_num_width'(en_bar));
	check_all("bar_wr_enabled");
	bar_access(1'b1, hm_bar_num_width'(dis_bar));
	check_all("bar_wr_disabled");
	bar_access(1'b0, hm_bar_num_width'(en_bar));
	check_all("bar_rd_enabled");
	bar_access(1'b0, hm_bar_num_width'(dis_bar));
	check_all("bar_rd_disabled");
	for (int n = 0; n < 6; n++) begin
		bar_access(random_between(0, 1) == 1,
			hm_bar_num_width'(random_between(0, hm_bar_count - 1)));
		check_all("bar_random");
	end

	clear_flags();
	check_all("flag_clear");
	set_link(1'b1);
	check_all("link_down");
	run_xfer(1'b0, 4);
	check_all("link_down_rx");
	run_xfer(1'b1, 4);
	check_all("link_down_tx");
	bar_access(1'b1, hm_bar_num_width'(en_bar));
	check_all("link_down_bar_wr");
	bar_access(1'b1, hm_bar_num_width'(dis_bar));
	check_all("link_down_bar_drop");
	bar_access(1'b0, hm_bar_num_width'(dis_bar));
	check_all("link_down_bar_rd");
	set_link(1'b0);
	check_all("link_restored");

	$display("All tests passed!");
	$finish;
end

endmodule

`default_nettype wire

// File: verilog.f
verilog/hm_trn_pkg.sv
verilog/hm_sys_pkg.sv
verilog/psync.sv
verilog/hm_sync.sv
verilog/hm_trn_engine.sv
verilog/hm_sys_regs.sv
verilog/hm_top.sv
tb/hm_tb.sv

// File: verilog/hm_sync.sv
`timescale 1ns/10ps
`default_nettype none

module hm_sync import hm_trn_pkg::*; (
	input wire logic sys_clk,
	input wire logic trn_clk,
	input wire logic reset,
	input wire hm_trn_events_t trn_events,
	input wire hm_xfer_state_t trn_state_rx,
	input wire hm_xfer_state_t trn_state_tx,
	input wire hm_xfer_state_t trn_state,
	input wire hm_trn_counts_t trn_counts,
	input wire logic [hm_bar_num_width-1:0] trn_write_bar_number,
	input wire logic trn_lnk_up_n,
	input wire logic [hm_bar_count-1:0] sys_bar_bitmap,
	output hm_trn_events_t sys_events,
	output hm_xfer_state_t sys_state_rx,
	output hm_xfer_state_t sys_state_tx,
	output hm_xfer_state_t sys_state,
	output hm_trn_counts_t sys_counts,
	output logic [hm_bar_num_width-1:0] sys_write_bar_number,
	output logic sys_lnk_up_n,
	output logic [hm_bar_count-1:0] trn_bar_bitmap
);

logic [$bits(hm_trn_events_t)-1:0] trn_event_bits;
logic [$bits(hm_trn_events_t)-1:0] sys_event_bits;
hm_xfer_state_t state_rx_meta;
hm_xfer_state_t state_tx_meta;
hm_xfer_state_t state_meta;
logic [hm_bar_num_width-1:0] bar_number_meta;
logic lnk_up_n_meta;
logic [hm_bar_count-1:0] bitmap_meta;
logic [hm_count_num-1:0][hm_count_width-1:0] trn_bin;
logic [hm_count_num-1:0][hm_count_width-1:0] trn_gray;
logic [hm_count_num-1:0][hm_count_width-1:0] gray_meta;
logic [hm_count_num-1:0][hm_count_width-1:0] gray_sync;
logic [hm_count_num-1:0][hm_count_width-1:0] sys_bin;

function automatic logic [hm_count_width-1:0] bin2gray(input logic [hm_count_width-1:0] b);
	return b ^ (b >> 1);
endfunction

function automatic logic [hm_count_width-1:0] gray2bin(input logic [hm_count_width-1:0] g);
	logic [hm_count_width-1:0] b;
	b[hm_count_width-1] = g[hm_count_width-1];
	for (int n = hm_count_width - 2; n >= 0; n--) begin
		b[n] = b[n+1] ^ g[n];
	end
	return b;
endfunction

assign trn_event_bits = trn_events;
assign sys_events = sys_event_bits;

for (genvar e = 0; e < $bits(hm_trn_events_t); e++) begin : g_event
	psync ps_event (
		.clk1(trn_clk),
		.clk2(sys_clk),
		.reset(reset),
		.i(trn_event_bits[e]),
		.o(sys_event_bits[e])
	);
end

always_ff @(posedge sys_clk) begin
	if (reset) begin
		state_rx_meta <= xfer_idle;
		state_tx_meta <= xfer_idle;
		state_meta <= xfer_idle;
		sys_state_rx <= xfer_idle;
		sys_state_tx <= xfer_idle;
		sys_state <= xfer_idle;
		bar_number_meta <= '0;
		sys_write_bar_number <= '0;
		lnk_up_n_meta <= 1'b1; // Link reads as down.
		sys_lnk_up_n <= 1'b1;
	end else begin
		state_rx_meta <= trn_state_rx;
		state_tx_meta <= trn_state_tx;
		state_meta <= trn_state;
		sys_state_rx <= state_rx_meta;
		sys_state_tx <= state_tx_meta;
		sys_state <= state_meta;
		bar_number_meta <= trn_write_bar_number;
		sys_write_bar_number <= bar_number_meta;
		lnk_up_n_meta <= trn_lnk_up_n;
		sys_lnk_up_n <= lnk_up_n_meta;
	end
end

always_ff @(posedge trn_clk) begin
	if (reset) begin
		bitmap_meta <= '0;
		trn_bar_bitmap <= '0;
	end else begin
		bitmap_meta <= sys_bar_bitmap;
		trn_bar_bitmap <= bitmap_meta;
	end
end

assign trn_bin = trn_counts;
assign sys_counts = sys_bin;

always_ff @(posedge trn_clk) begin
	if (reset) begin
		trn_gray <= '0;
	end else begin
		for (int k = 0; k < hm_count_num; k++) begin
			trn_gray[k] <= bin2gray(trn_bin[k]); // One bit changes per step.
		end
	end
end

always_ff @(posedge sys_clk) begin
	if (reset) begin
		gray_meta <= '0;
		gray_sync <= '0;
		sys_bin <= '0;
	end else begin
		gray_meta <= trn_gray;
		gray_sync <= gray_meta;
		for (int k = 0; k < hm_count_num; k++) begin
			sys_bin[k] <= gray2bin(gray_sync[k]);
		end
	end
end

for (genvar k = 0; k < hm_count_num; k++) begin : g_count_check
	a_count_step: assert property (@(posedge sys_clk) disable iff (reset)
		(sys_bin[k] - $past(sys_bin[k])) <= 1)
		else $error("hm_sync: counter %0d jumped", k);
end

endmodule

`default_nettype wire

// File: verilog/hm_sys_pkg.sv
`default_nettype none

package hm_sys_pkg;

localparam int hm_event_count_width = 16;

// Sticky copies of the crossed event pulses.
typedef struct packed {
	logic rx_timeout;
	logic tx_timeout;
	logic hm_end;
	logic write_bar;
	logic read_exp;
} hm_sys_flags_t;

endpackage

`default_nettype wire

// File: verilog/hm_sys_regs.sv
`timescale 1ns/10ps
`default_nettype none

module hm_sys_regs import hm_trn_pkg::*, hm_sys_pkg::*; (
	input wire logic sys_clk,
	input wire logic reset,
	input wire hm_trn_events_t sys_events,
	input wire logic [hm_bar_num_width-1:0] sys_write_bar_number,
	input wire logic bitmap_wr,
	input wire logic flag_clear,
	input wire logic [hm_bar_count-1:0] bitmap_data,
	output hm_sys_flags_t flags,
	output logic [hm_event_count_width-1:0] rx_timeout_count,
	output logic [hm_event_count_width-1:0] tx_timeout_count,
	output logic [hm_bar_num_width-1:0] last_bar_number,
	output logic [hm_bar_count-1:0] bar_bitmap
);

hm_sys_flags_t flag_set;

always_comb begin
	flag_set.rx_timeout = sys_events.rx_timeout;
	flag_set.tx_timeout = sys_events.tx_timeout;
	flag_set.hm_end = sys_events.hm_end;
	flag_set.write_bar = sys_events.write_bar;
	flag_set.read_exp = sys_events.read_exp;
end

always_ff @(posedge sys_clk) begin
	if (reset) begin
		flags <= '0;
	end else if (flag_clear) begin
		flags <= flag_set; // A new event survives the clear.
	end else begin
		flags <= flags | flag_set;
	end
end

always_ff @(posedge sys_clk) begin
	if (reset) begin
		rx_timeout_count <= '0;
		tx_timeout_count <= '0;
	end else begin
		if (sys_events.rx_timeout) begin
			rx_timeout_count <= rx_timeout_count + 1'b1;
		end
		if (sys_events.tx_timeout) begin
			tx_timeout_count <= tx_timeout_count + 1'b1;
		end
	end
end

// The bar number settles two sys cycles after the engine latches it, before the pulse.
always_ff @(posedge sys_clk) begin
	if (reset) begin
		last_bar_number <= '0;
	end else if (sys_events.write_bar) begin
		last_bar_number <= sys_write_bar_number;
	end
end

always_ff @(posedge sys_clk) begin
	if (reset) begin
		bar_bitmap <= '0;
	end else if (bitmap_wr) begin
		bar_bitmap <= bitmap_data; // One bit per enabled bar.
	end
end

endmodule

`default_nettype wire

// File: verilog/hm_top.sv
`timescale 1ns/10ps
`default_nettype none

module hm_top import hm_trn_pkg::*, hm_sys_pkg::*; (
	input wire logic sys_clk,
	input wire logic trn_clk,
	input wire logic reset,
	input wire logic rx_start,
	input wire logic rx_done,
	input wire logic tx_start,
	input wire logic tx_done,
	input wire logic bar_wr,
	input wire logic bar_rd,
	input wire logic [hm_bar_num_width-1:0] bar_num,
	input wire logic lnk_up_n,
	input wire logic bitmap_wr,
	input wire logic [hm_bar_count-1:0] bitmap_data,
	input wire logic flag_clear,
	output hm_sys_flags_t flags,
	output logic [hm_event_count_width-1:0] rx_timeout_count,
	output logic [hm_event_count_width-1:0] tx_timeout_count,
	output logic [hm_bar_num_width-1:0] last_bar_number,
	output logic [hm_bar_count-1:0] bar_bitmap,
	output hm_trn_counts_t sys_counts,
	output hm_xfer_state_t sys_state_rx,
	output hm_xfer_state_t sys_state_tx,
	output hm_xfer_state_t sys_state,
	output logic sys_lnk_up_n
);

hm_trn_events_t trn_events;
hm_trn_events_t sys_events;
hm_xfer_state_t trn_state_rx;
hm_xfer_state_t trn_state_tx;
hm_xfer_state_t trn_state;
hm_trn_counts_t trn_counts;
logic [hm_bar_num_width-1:0] trn_write_bar_number;
logic [hm_bar_num_width-1:0] sys_write_bar_number;
logic [hm_bar_count-1:0] trn_bar_bitmap;

hm_trn_engine engine_i (
	.trn_clk(trn_clk),
	.reset(reset),
	.rx_start(rx_start),
	.rx_done(rx_done),
	.tx_start(tx_start),
	.tx_done(tx_done),
	.bar_wr(bar_wr),
	.bar_rd(bar_rd),
	.bar_num(bar_num),
	.lnk_up_n(lnk_up_n),
	.bar_bitmap(trn_bar_bitmap),
	.events(trn_events),
	.state_rx(trn_state_rx),
	.state_tx(trn_state_tx),
	.engine_state(trn_state),
	.counts(trn_counts),
	.write_bar_number(trn_write_bar_number)
);

hm_sync sync_i (
	.sys_clk(sys_clk),
	.trn_clk(trn_clk),
	.reset(reset),
	.trn_events(trn_events),
	.trn_state_rx(trn_state_rx),
	.trn_state_tx(trn_state_tx),
	.trn_state(trn_state),
	.trn_counts(trn_counts),
	.trn_write_bar_number(trn_write_bar_number),
	.trn_lnk_up_n(lnk_up_n),
	.sys_bar_bitmap(bar_bitmap),
	.sys_events(sys_events),
	.sys_state_rx(sys_state_rx),
	.sys_state_tx(sys_state_tx),
	.sys_state(sys_state),
	.sys_counts(sys_counts),
	.sys_write_bar_number(sys_write_bar_number),
	.sys_lnk_up_n(sys_lnk_up_n),
	.trn_bar_bitmap(trn_bar_bitmap)
);

hm_sys_regs regs_i (
	.sys_clk(sys_clk),
	.reset(reset),
	.sys_events(sys_events),
	.sys_write_bar_number(sys_write_bar_number),
	.bitmap_wr(bitmap_wr),
	.flag_clear(flag_clear),
	.bitmap_data(bitmap_data),
	.flags(flags),
	.rx_timeout_count(rx_timeout_count),
	.tx_timeout_count(tx_timeout_count),
	.last_bar_number(last_bar_number),
	.bar_bitmap(bar_bitmap)
);

endmodule

`default_nettype wire

// File: verilog/hm_trn_engine.sv
`timescale 1ns/10ps
`default_nettype none

module hm_trn_engine import hm_trn_pkg::*; (
	input wire logic trn_clk,
	input wire logic reset,
	input wire logic rx_start,
	input wire logic rx_done,
	input wire logic tx_start,
	input wire logic tx_done,
	input wire logic bar_wr,
	input wire logic bar_rd,
	input wire logic [hm_bar_num_width-1:0] bar_num,
	input wire logic lnk_up_n,
	input wire logic [hm_bar_count-1:0] bar_bitmap,
	output hm_trn_events_t events,
	output hm_xfer_state_t state_rx,
	output hm_xfer_state_t state_tx,
	output hm_xfer_state_t engine_state,
	output hm_trn_counts_t counts,
	output logic [hm_bar_num_width-1:0] write_bar_number
);

logic link_ok;
logic [1:0] start;
logic [1:0] done;
logic [1:0] finish;
logic [1:0] expire;
hm_xfer_state_t state [2];
hm_xfer_state_t state_nxt [2];
logic [hm_timer_width-1:0] timer [2];
logic bar_hit;
logic wr_ok;
logic rd_ok;

assign link_ok = !lnk_up_n;
assign start = {tx_start, rx_start} & {2{link_ok}}; // Side 0 is rx, side 1 is tx.
assign done = {tx_done, rx_done} & {2{link_ok}};
assign bar_hit = bar_bitmap[bar_num];
assign wr_ok = bar_wr & link_ok;
assign rd_ok = bar_rd & link_ok;

for (genvar s = 0; s < 2; s++) begin : g_side
	localparam int limit = (s == 0) ? hm_rx_timeout_cycles : hm_tx_timeout_cycles;

	assign finish[s] = (state[s] == xfer_busy) && done[s];
	assign expire[s] = (state[s] == xfer_busy) && !done[s] &&
		(timer[s] == hm_timer_width'(limit)); // A done on the last cycle still counts.

	always_comb begin
		state_nxt[s] = state[s];
		case (state[s])
			xfer_idle: begin
				if (start[s]) begin
					state_nxt[s] = xfer_busy;
				end
			end
			xfer_busy: begin
				if (finish[s]) begin
					state_nxt[s] = xfer_done;
				end else if (expire[s]) begin
					state_nxt[s] = xfer_timeout;
				end
			end
			default: state_nxt[s] = xfer_idle; // Done and timeout last one cycle.
		endcase
	end

	always_ff @(posedge trn_clk) begin
		if (reset) begin
			state[s] <= xfer_idle;
			timer[s] <= '0;
		end else begin
			state[s] <= state_nxt[s];
			if (state[s] != xfer_busy) begin
				timer[s] <= hm_timer_width'(1);
			end else begin
				timer[s] <= timer[s] + 1'b1;
			end
		end
	end
end

assign state_rx = state[0];
assign state_tx = state[1];

always_ff @(posedge trn_clk) begin
	if (reset) begin
		events <= '0;
		counts <= '0;
		write_bar_number <= '0;
		engine_state <= xfer_idle;
	end else begin
		events.rx_timeout <= expire[0];
		events.tx_timeout <= expire[1];
		events.hm_end <= finish[1];
		events.write_bar <= wr_ok && bar_hit;
		events.read_exp <= rd_ok && !bar_hit;
		events.drop <= wr_ok && !bar_hit;
		counts.cpt_rx <= counts.cpt_rx + finish[0];
		counts.cpt_tx <= counts.cpt_tx + finish[1];
		counts.cpt_drop <= counts.cpt_drop + (wr_ok && !bar_hit);
		if (wr_ok && bar_hit) begin
			write_bar_number <= bar_num;
		end
		if (state_nxt[0] == xfer_busy || state_nxt[1] == xfer_busy) begin
			engine_state <= xfer_busy;
		end else if (state_nxt[0] == xfer_timeout || state_nxt[1] == xfer_timeout) begin
			engine_state <= xfer_timeout;
		end else if (state_nxt[0] == xfer_done || state_nxt[1] == xfer_done) begin
			engine_state <= xfer_done;
		end else begin
			engine_state <= xfer_idle;
		end
	end
end

a_rx_count_busy: assert property (@(posedge trn_clk) disable iff (reset)
	(counts.cpt_rx != $past(counts.cpt_rx)) |-> $past(state_rx) != xfer_idle)
	else $error("hm_trn_engine: rx done counted while idle");

a_tx_count_busy: assert property (@(posedge trn_clk) disable iff (reset)
	(counts.cpt_tx != $past(counts.cpt_tx)) |-> $past(state_tx) != xfer_idle)
	else $error("hm_trn_engine: tx done counted while idle");

a_count_monotonic: assert property (@(posedge trn_clk) disable iff (reset)
	counts.cpt_rx >= $past(counts.cpt_rx) && counts.cpt_tx >= $past(counts.cpt_tx) &&
	counts.cpt_drop >= $past(counts.cpt_drop))
	else $error("hm_trn_engine: counter decreased");

endmodule

`default_nettype wire

// File: verilog/hm_trn_pkg.sv
`default_nettype none

package hm_trn_pkg;

localparam int hm_rx_timeout_cycles = 16; // Trn cycles from start to done.
localparam int hm_tx_timeout_cycles = 24;
localparam int hm_timer_width = 5; // Holds the larger limit.
localparam int hm_bar_count = 32;
localparam int hm_bar_num_width = 5;
localparam int hm_count_width = 32;
localparam int hm_count_num = 3;

typedef enum logic [1:0] {
	xfer_idle = 2'd0,
	xfer_busy = 2'd1,
	xfer_done = 2'd2,
	xfer_timeout = 2'd3
} hm_xfer_state_t;

// One-cycle trn pulses.
typedef struct packed {
	logic rx_timeout;
	logic tx_timeout;
	logic hm_end;
	logic write_bar;
	logic read_exp;
	logic drop;
} hm_trn_events_t;

typedef struct packed {
	logic [hm_count_width-1:0] cpt_rx;
	logic [hm_count_width-1:0] cpt_tx;
	logic [hm_count_width-1:0] cpt_drop;
} hm_trn_counts_t;

endpackage

`default_nettype wire

// File: verilog/psync.sv
`timescale 1ns/10ps
`default_nettype none

module psync (
	input wire logic clk1,
	input wire logic clk2,
	input wire logic reset,
	input wire logic i,
	output logic o
);

logic toggle;
logic [2:0] sync;

always_ff @(posedge clk1) begin
	if (reset) begin
		toggle <= 1'b0;
	end else if (i) begin
		toggle <= ~toggle; // One edge per pulse.
	end
end

always_ff @(posedge clk2) begin
	if (reset) begin
		sync <= 3'b000;
	end else begin
		sync <= {sync[1:0], toggle};
	end
end

assign o = sync[2] ^ sync[1]; // High for one clk2 cycle per edge.

// Back-to-back pulses would cancel in the toggle.
a_single_pulse: assert property (@(posedge clk1) disable iff (reset) i |=> !i)
	else $error("psync: input high on two consecutive cycles");

endmodule

`default_nettype wire
